//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module readonly_cache_tb -f ro_cache.f
	./obj_dir/Vreadonly_cache_tb +verilator+error+limit+1000 > sim.log 2>&1; \
	status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- bench/readonly_cache_sva.sv
// Wishbone protocol assertions bound to the read-only cache top level
`timescale 1ns/10ps

module readonly_cache_sva (
    input logic clk,
    input logic rst,
    input logic cpu_ack,
    input logic mem_cyc,
    input logic mem_stb,
    input logic mem_ack,
    input logic [cache_pkg::ADDR_WIDTH-1:0] mem_adr
);

    int unsigned fail_count = 0;

    // Read data offered for a single cycle
    ack_pulse: assert property (@(posedge clk) disable iff (rst) cpu_ack |=> !cpu_ack)
        else begin
            fail_count++;
            $error("cpu_ack stayed high for more than one cycle");
        end

    // Strobe stays up inside the bus cycle until memory answers
    stb_held: assert property (@(posedge clk) disable iff (rst)
        (mem_stb && !mem_ack) |=> (mem_stb && mem_cyc))
        else begin
            fail_count++;
            $error("mem_stb or mem_cyc dropped before mem_ack");
        end

    // Address held until memory answers
    adr_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_stb && !mem_ack) |=> $stable(mem_adr))
        else begin
            fail_count++;
            $error("mem_adr changed while waiting for mem_ack");
        end

endmodule : readonly_cache_sva

bind readonly_cache readonly_cache_sva sva_checks (
    .clk(clk),
    .rst(rst),
    .cpu_ack(cpu_ack),
    .mem_cyc(mem_cyc),
    .mem_stb(mem_stb),
    .mem_ack(mem_ack),
    .mem_adr(mem_adr)
);

//--- bench/readonly_cache_tb.sv
// Read-only cache testbench with memory slave model, cache model and random reads
`timescale 1ns/10ps

module readonly_cache_tb;

    localparam int NUM_LINES = 8;
    localparam int ASSOCIATIVITY = 2;
    localparam int ADDR_WIDTH = cache_pkg::ADDR_WIDTH;
    localparam int LINE_WIDTH = cache_pkg::LINE_WIDTH;
    localparam int INDEX_WIDTH = $clog2(NUM_LINES);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH;
    localparam int WAY_WIDTH = $clog2(ASSOCIATIVITY);
    localparam int TIMEOUT_CYCLES = 40;
    localparam logic [31:0] MEM_XOR = 32'h5A3C_96E1;

    logic clk = 1'b0;
    logic rst;
    logic cpu_cyc;
    logic cpu_stb;
    logic [ADDR_WIDTH-1:0] cpu_adr;
    logic [cache_pkg::SEL_WIDTH-1:0] cpu_sel;
    logic cpu_ack;
    logic [LINE_WIDTH-1:0] cpu_dat;
    logic mem_cyc;
    logic mem_stb;
    logic [ADDR_WIDTH-1:0] mem_adr;
    logic [cache_pkg::SEL_WIDTH-1:0] mem_sel;
    logic mem_ack = 1'b0;
    logic [LINE_WIDTH-1:0] mem_dat = '0;

    int mem_access_count = 0;
    int zero_delay_count = 0;
    int mem_wait = 0;
    bit mem_pending = 1'b0;
    int check_count = 0;
    int mismatch_count = 0;
    int timeout_count = 0;

    // Cache model, reset leaves way 1 most recent so way 0 fills first
    logic [TAG_WIDTH-1:0] model_tag [NUM_LINES][ASSOCIATIVITY];
    logic [ASSOCIATIVITY-1:0] model_valid [NUM_LINES] = '{default: '0};
    logic [WAY_WIDTH-1:0] model_mru [NUM_LINES] = '{default: '1};
    logic [TAG_WIDTH-1:0] tag_pool [4] = '{9'h000, 9'h0A5, 9'h15A, 9'h1FF};

    always #20 clk = ~clk;

    readonly_cache #(
        .NUM_LINES(NUM_LINES),
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .cpu_cyc(cpu_cyc),
        .cpu_stb(cpu_stb),
        .cpu_adr(cpu_adr),
        .cpu_sel(cpu_sel),
        .cpu_ack(cpu_ack),
        .cpu_dat(cpu_dat),
        .mem_cyc(mem_cyc),
        .mem_stb(mem_stb),
        .mem_adr(mem_adr),
        .mem_sel(mem_sel),
        .mem_ack(mem_ack),
        .mem_dat(mem_dat)
    );

    // Memory contents, each word is the address, its word number and a constant
    function automatic logic [LINE_WIDTH-1:0] memory_line(input logic [ADDR_WIDTH-1:0] adr);
        logic [LINE_WIDTH-1:0] line;
        for (int w = 0; w < LINE_WIDTH / 32; w++) begin
            line[w*32 +: 32] = ((32'(adr) << 4) | 32'(w)) ^ MEM_XOR;
        end
        return line;
    endfunction

    // Memory slave, acks each strobe after 0 to 5 cycles
    always @(negedge clk) begin
        if (rst) begin
            mem_ack <= 1'b0;
            mem_pending <= 1'b0;
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_stb && !mem_pending) begin
            mem_wait = $urandom_range(5);
            if (mem_wait == 0) begin
                mem_ack <= 1'b1;
                mem_dat <= memory_line(mem_adr);
                mem_access_count <= mem_access_count + 1;
                zero_delay_count <= zero_delay_count + 1;
            end else begin
                mem_pending <= 1'b1;
            end
        end else if (mem_pending) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                mem_pending <= 1'b0;
                mem_ack <= 1'b1;
                mem_dat <= memory_line(mem_adr);
                mem_access_count <= mem_access_count + 1;
            end
        end
    end

    task automatic check_line(input logic [LINE_WIDTH-1:0] got,
                              input logic [LINE_WIDTH-1:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sel(input logic [cache_pkg::SEL_WIDTH-1:0] got,
                             input logic [cache_pkg::SEL_WIDTH-1:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Predict hit or miss, then update tags and recency the way the LRU rule does
    task automatic model_lookup(input logic [ADDR_WIDTH-1:0] adr, output bit exp_hit);
        logic [INDEX_WIDTH-1:0] idx;
        logic [TAG_WIDTH-1:0] tag;
        logic [WAY_WIDTH-1:0] way;
        idx = adr[INDEX_WIDTH-1:0];
        tag = adr[ADDR_WIDTH-1:INDEX_WIDTH];
        exp_hit = 1'b0;
        way = ~model_mru[idx];
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                exp_hit = 1'b1;
                way = WAY_WIDTH'(w);
            end
        end
        if (!exp_hit) begin
            model_tag[idx][way] = tag;
            model_valid[idx][way] = 1'b1;
        end
        model_mru[idx] = way;
    endtask

    // One CPU read, returns the line, memory activity and cycles to cpu_ack
    task automatic read_line(input logic [ADDR_WIDTH-1:0] adr, output logic [LINE_WIDTH-1:0] data,
                             output bit used_mem, output int cycles);
        bit acked;
        @(negedge clk);
        cpu_cyc <= 1'b1;
        cpu_stb <= 1'b1;
        cpu_adr <= adr;
        cpu_sel <= '1;
        used_mem = 1'b0;
        acked = 1'b0;
        cycles = 0;
        data = 'x;
        while (!acked && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (mem_cyc) begin
                used_mem = 1'b1;
                // Fills always ask for every byte lane
                check_sel(mem_sel, '1, "mem_sel during a fill");
            end
            if (cpu_ack) begin
                acked = 1'b1;
                data = cpu_dat;
            end
        end
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        if (!acked) begin
            timeout_count++;
            $display("TIMEOUT at %0t: no cpu_ack for address %h after %0d cycles",
                     $time, adr, TIMEOUT_CYCLES);
        end
        @(negedge clk);
        check_bit(cpu_ack, 1'b0, "cpu_ack low after the acked cycle");
    endtask

    task automatic checked_read(input logic [ADDR_WIDTH-1:0] adr, input string label,
                                output bit was_miss);
        logic [LINE_WIDTH-1:0] data;
        bit used_mem;
        bit exp_hit;
        int cycles;
        int count_before;
        count_before = mem_access_count;
        model_lookup(adr, exp_hit);
        read_line(adr, data, used_mem, cycles);
        check_line(data, memory_line(adr), {label, " line data"});
        check_bit(used_mem, !exp_hit, {label, " memory access"});
        check_bit((mem_access_count - count_before) == (exp_hit ? 0 : 1), 1'b1,
                  {label, " memory access count"});
        if (exp_hit) begin
            check_bit(cycles == 2, 1'b1, {label, " hit latency of 2 cycles"});
        end
        was_miss = used_mem;
    endtask

    initial begin
        bit was_miss;
        logic [TAG_WIDTH-1:0] seq_tag [5];
        logic [4:0] seq_miss;
        logic [1:0] pool_sel;
        logic [INDEX_WIDTH-1:0] idx;
        void'($urandom(33448));
        rst = 1'b1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_adr = '0;
        cpu_sel = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;

        // Quiet bus after reset, then a cold read and its repeat
        repeat (3) begin
            @(negedge clk);
            check_bit(cpu_ack, 1'b0, "cpu_ack idle after reset");
            check_bit(mem_cyc, 1'b0, "mem_cyc idle after reset");
        end
        checked_read(12'h123, "first read", was_miss);
        check_bit(was_miss, 1'b1, "first read goes to memory");
        checked_read(12'h123, "repeat read", was_miss);
        check_bit(was_miss, 1'b0, "repeat read served from cache");

        // A, B, A, C, B at index 5, only the second A hits
        seq_tag = '{9'h011, 9'h022, 9'h011, 9'h033, 9'h022};
        seq_miss = 5'b11011;
        for (int i = 0; i < 5; i++) begin
            checked_read({seq_tag[i], 3'd5}, "LRU sequence", was_miss);
            check_bit(was_miss, seq_miss[i], "LRU sequence hit or miss");
        end

        // Fresh tags, every read is a fill with a random memory delay
        for (int i = 0; i < 40; i++) begin
            idx = INDEX_WIDTH'($urandom_range(NUM_LINES - 1));
            checked_read({TAG_WIDTH'(32'h100 + i), idx}, "cold read", was_miss);
            check_bit(was_miss, 1'b1, "cold read goes to memory");
        end
        check_bit(zero_delay_count > 0, 1'b1, "zero delay memory answer seen");

        // Small tag pool over all indexes keeps evictions frequent
        for (int i = 0; i < 400; i++) begin
            pool_sel = 2'($urandom_range(3));
            idx = INDEX_WIDTH'($urandom_range(NUM_LINES - 1));
            checked_read({tag_pool[pool_sel], idx}, "random read", was_miss);
        end

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 check_count, mismatch_count, timeout_count, UUT.sva_checks.fail_count);
        if (mismatch_count == 0 && timeout_count == 0 && UUT.sva_checks.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : readonly_cache_tb

//--- ro_cache.f
src/cache_pkg.sv
src/cache_way.sv
src/cache_lru.sv
src/readonly_cache_datapath.sv
src/readonly_cache_control.sv
src/readonly_cache.sv
bench/readonly_cache_sva.sv
bench/readonly_cache_tb.sv

//--- src/cache_lru.sv
// Per-index recency tracking that yields the victim way for a fill
`timescale 1ns/10ps

module cache_lru #(
    parameter int NUM_LINES = 8,
    parameter int ASSOCIATIVITY = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] mru_in,
    input  logic [$clog2(NUM_LINES)-1:0] index_in,
    input  logic load_in,
    output logic [$clog2(ASSOCIATIVITY)-1:0] lru_out
);

    localparam int WAY_WIDTH = $clog2(ASSOCIATIVITY);

    if (ASSOCIATIVITY == 2) begin : g_two_way
        // One bit per index, the victim is simply the other way
        logic [NUM_LINES-1:0] mru;

        // Reset marks way 1 as recent so every index evicts way 0 first
        always_ff @(posedge clk) begin
            if (rst) begin
                mru <= '1;
            end else if (load_in) begin
                mru[index_in] <= mru_in[0];
            end
        end

        assign lru_out = ~mru[index_in];
    end else begin : g_multi_way
        // Age per way per index, 0 is the most recent
        logic [WAY_WIDTH-1:0] age [NUM_LINES][ASSOCIATIVITY];
        logic [WAY_WIDTH-1:0] mru_age;

        assign mru_age = age[index_in][mru_in];

        // Ways no older than the touched one move back by one
        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < NUM_LINES; i++) begin
                    for (int w = 0; w < ASSOCIATIVITY; w++) begin
                        age[i][w] <= '0;
                    end
                end
            end else if (load_in) begin
                for (int w = 0; w < ASSOCIATIVITY; w++) begin
                    if (WAY_WIDTH'(w) == mru_in) begin
                        age[index_in][w] <= '0;
                    end else if (age[index_in][w] <= mru_age) begin
                        age[index_in][w] <= age[index_in][w] + 1'b1;
                    end
                end
            end
        end

        // Oldest way wins, strict compare keeps the lowest index on ties
        always_comb begin : victim_search
            logic [WAY_WIDTH-1:0] best;
            logic [WAY_WIDTH-1:0] best_age;
            best = '0;
            best_age = age[index_in][0];
            for (int w = 1; w < ASSOCIATIVITY; w++) begin
                if (age[index_in][w] > best_age) begin
                    best = WAY_WIDTH'(w);
                    best_age = age[index_in][w];
                end
            end
            lru_out = best;
        end
    end

endmodule : cache_lru

//--- src/cache_pkg.sv
// Package with cache address, select and line widths and the controller state type

package cache_pkg;

    // CPU line address, one address per 128-bit line
    localparam int ADDR_WIDTH = 12;

    // Byte lanes across one line
    localparam int SEL_WIDTH = 16;

    // Line width is fixed, the datapath does not scale it
    localparam int LINE_WIDTH = 128;

    // Controller sequence for one CPU read
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_FETCH,
        ST_RESPOND
    } ctrl_state_t;

endpackage : cache_pkg

//--- src/cache_way.sv
// Single cache way with data, tag and valid arrays, combinational read and hit compare
`timescale 1ns/10ps

module cache_way #(
    parameter int NUM_LINES = 8
) (
    input  logic clk,
    input  logic rst,

    // Fill control from the datapath
    input  logic load,
    input  logic [cache_pkg::ADDR_WIDTH-$clog2(NUM_LINES)-1:0] tag_in,
    input  logic [$clog2(NUM_LINES)-1:0] index_in,
    input  logic [cache_pkg::LINE_WIDTH-1:0] data_in,

    // Lookup results at index_in
    output logic [cache_pkg::LINE_WIDTH-1:0] data_out,
    output logic hit_out
);

    localparam int INDEX_WIDTH = $clog2(NUM_LINES);
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH;

    logic [cache_pkg::LINE_WIDTH-1:0] data_mem [NUM_LINES];
    logic [TAG_WIDTH-1:0] tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid;

    // Valid bits start clear so nothing hits after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (load) begin
            valid[index_in] <= 1'b1;
        end
    end

    // Line payload and tag written together on a fill
    always_ff @(posedge clk) begin
        if (load) begin
            data_mem[index_in] <= data_in;
            tag_mem[index_in] <= tag_in;
        end
    end

    assign data_out = data_mem[index_in];

    // Hit needs a valid entry with a matching tag
    assign hit_out = valid[index_in] && (tag_mem[index_in] == tag_in);

endmodule : cache_way

//--- src/readonly_cache.sv
// Read-only cache top level joining the controller and the datapath
`timescale 1ns/10ps

module readonly_cache #(
    parameter int NUM_LINES = 8,
    parameter int ASSOCIATIVITY = 2
) (
    input  logic clk,
    input  logic rst,

    // CPU side Wishbone slave
    input  logic cpu_cyc,
    input  logic cpu_stb,
    input  logic [cache_pkg::ADDR_WIDTH-1:0] cpu_adr,
    // Byte select is part of the bus, a read always returns the full line
    input  logic [cache_pkg::SEL_WIDTH-1:0] cpu_sel,
    output logic cpu_ack,
    output logic [cache_pkg::LINE_WIDTH-1:0] cpu_dat,

    // Memory side Wishbone master
    output logic mem_cyc,
    output logic mem_stb,
    output logic [cache_pkg::ADDR_WIDTH-1:0] mem_adr,
    output logic [cache_pkg::SEL_WIDTH-1:0] mem_sel,
    input  logic mem_ack,
    input  logic [cache_pkg::LINE_WIDTH-1:0] mem_dat
);

    logic [ASSOCIATIVITY-1:0] hit;
    logic [$clog2(ASSOCIATIVITY)-1:0] lru;
    logic [$clog2(ASSOCIATIVITY)-1:0] way_sel;
    logic load;
    logic load_lru;

    readonly_cache_control #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) _control (
        .clk(clk),
        .rst(rst),
        .cpu_cyc(cpu_cyc),
        .cpu_stb(cpu_stb),
        .cpu_ack(cpu_ack),
        .mem_cyc(mem_cyc),
        .mem_stb(mem_stb),
        .mem_ack(mem_ack),
        .hit(hit),
        .lru(lru),
        .way_sel(way_sel),
        .load(load),
        .load_lru(load_lru)
    );

    readonly_cache_datapath #(
        .NUM_LINES(NUM_LINES),
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) _datapath (
        .clk(clk),
        .rst(rst),
        .way_sel(way_sel),
        .load(load),
        .load_lru(load_lru),
        .cpu_adr(cpu_adr),
        .mem_dat(mem_dat),
        .hit(hit),
        .lru(lru),
        .cpu_dat(cpu_dat),
        .mem_adr(mem_adr),
        .mem_sel(mem_sel)
    );

endmodule : readonly_cache

//--- src/readonly_cache_control.sv
// Cache controller FSM sequencing the CPU and memory Wishbone handshakes
`timescale 1ns/10ps

module readonly_cache_control #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic clk,
    input  logic rst,

    // CPU side Wishbone slave
    input  logic cpu_cyc,
    input  logic cpu_stb,
    output logic cpu_ack,

    // Memory side Wishbone master
    output logic mem_cyc,
    output logic mem_stb,
    input  logic mem_ack,

    // Datapath status and control
    input  logic [ASSOCIATIVITY-1:0] hit,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] lru,
    output logic [$clog2(ASSOCIATIVITY)-1:0] way_sel,
    output logic load,
    output logic load_lru
);

    localparam int WAY_WIDTH = $clog2(ASSOCIATIVITY);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_next;

    logic [WAY_WIDTH-1:0] hit_way;
    logic [WAY_WIDTH-1:0] way_reg;

    // Hitting way as an index, at most one bit is set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            if (hit[w]) begin
                hit_way = WAY_WIDTH'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::ST_IDLE;
            way_reg <= '0;
        end else begin
            state <= state_next;
            // Keep the chosen way so the respond cycle reads the right line
            if (state == cache_pkg::ST_CHECK) begin
                way_reg <= (|hit) ? hit_way : lru;
            end
        end
    end

    always_comb begin
        state_next = state;
        way_sel = way_reg;
        load = 1'b0;
        load_lru = 1'b0;
        cpu_ack = 1'b0;
        mem_cyc = 1'b0;
        mem_stb = 1'b0;
        case (state)
            cache_pkg::ST_IDLE: begin
                if (cpu_cyc && cpu_stb) begin
                    state_next = cache_pkg::ST_CHECK;
                end
            end
            cache_pkg::ST_CHECK: begin
                way_sel = hit_way;
                if (|hit) begin
                    load_lru = 1'b1;
                    state_next = cache_pkg::ST_RESPOND;
                end else begin
                    state_next = cache_pkg::ST_FETCH;
                end
            end
            cache_pkg::ST_FETCH: begin
                // Hold the bus request until memory answers
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                if (mem_ack) begin
                    load = 1'b1;
                    load_lru = 1'b1;
                    state_next = cache_pkg::ST_RESPOND;
                end
            end
            cache_pkg::ST_RESPOND: begin
                cpu_ack = 1'b1;
                state_next = cache_pkg::ST_IDLE;
            end
            default: begin
                state_next = cache_pkg::ST_IDLE;
            end
        endcase
    end

endmodule : readonly_cache_control

//--- src/readonly_cache_datapath.sv
// Cache datapath with address split, way array, load demux, output data mux and LRU
`timescale 1ns/10ps

module readonly_cache_datapath #(
    parameter int NUM_LINES = 8,
    parameter int ASSOCIATIVITY = 2
) (
    input  logic clk,
    input  logic rst,

    // From the controller
    input  logic [$clog2(ASSOCIATIVITY)-1:0] way_sel,
    input  logic load,
    input  logic load_lru,

    // CPU request and memory fill data
    input  logic [cache_pkg::ADDR_WIDTH-1:0] cpu_adr,
    input  logic [cache_pkg::LINE_WIDTH-1:0] mem_dat,

    // To the controller
    output logic [ASSOCIATIVITY-1:0] hit,
    output logic [$clog2(ASSOCIATIVITY)-1:0] lru,

    // Line back to the CPU, request out to memory
    output logic [cache_pkg::LINE_WIDTH-1:0] cpu_dat,
    output logic [cache_pkg::ADDR_WIDTH-1:0] mem_adr,
    output logic [cache_pkg::SEL_WIDTH-1:0] mem_sel
);

    localparam int INDEX_WIDTH = $clog2(NUM_LINES);
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH;

    logic [TAG_WIDTH-1:0] tag;
    logic [INDEX_WIDTH-1:0] index;
    logic [ASSOCIATIVITY-1:0] way_load;
    logic [cache_pkg::LINE_WIDTH-1:0] way_data [ASSOCIATIVITY];

    // Address split, upper bits are the tag
    assign tag = cpu_adr[cache_pkg::ADDR_WIDTH-1:INDEX_WIDTH];
    assign index = cpu_adr[INDEX_WIDTH-1:0];

    // Fills always fetch whole lines at the CPU address
    assign mem_adr = cpu_adr;
    assign mem_sel = '1;

    // Only the selected way takes the fill
    always_comb begin
        way_load = '0;
        way_load[way_sel] = load;
    end

    for (genvar w = 0; w < ASSOCIATIVITY; w++) begin : g_way
        cache_way #(
            .NUM_LINES(NUM_LINES)
        ) _cache_way (
            .clk(clk),
            .rst(rst),
            .load(way_load[w]),
            .tag_in(tag),
            .index_in(index),
            .data_in(mem_dat),
            .data_out(way_data[w]),
            .hit_out(hit[w])
        );
    end

    // Selected way's line goes back to the CPU
    assign cpu_dat = way_data[way_sel];

    cache_lru #(
        .NUM_LINES(NUM_LINES),
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) _cache_lru (
        .clk(clk),
        .rst(rst),
        .mru_in(way_sel),
        .index_in(index),
        .load_in(load_lru),
        .lru_out(lru)
    );

endmodule : readonly_cache_datapath
